// File: build.f
design/fetch_pkg.sv
design/instr_wb_master.sv
design/prefetch_unit.sv
design/if_stage.sv
design/fetch_top.sv
verification/wb_mem_model.sv
verification/tb_fetch_top.sv

// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  ////////////////////
  // Next-PC sources
  ////////////////////

  // Redirect source chosen by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5,
    PC_TRAP_NMI = 3'd6
  } pc_mux_e;

  // Controller request toward the fetch side
  typedef struct packed {
    logic       pc_set;
    pc_mux_e    pc_mux;
    logic [4:0] irq_id;
    logic       kill_if;
    logic       halt_if;
  } fetch_ctrl_t;

  ////////////////////
  // Fetch data path
  ////////////////////

  // One buffered word with the address it came from
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        bus_err;
  } fetch_entry_t;

  // IF/ID register contents
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        bus_err;
  } if_id_pipe_t;

  // Wishbone master outputs
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [3:0]  sel;
  } wb_req_t;

  // Bus answer from master to prefetch unit
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } fetch_resp_t;

endpackage

`default_nettype wire

// File: design/fetch_top.sv
`default_nettype none

module fetch_top #(
  parameter int FIFO_DEPTH = 2
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // Controller and redirect targets
  input  wire fetch_pkg::fetch_ctrl_t ctrl_i,
  input  wire logic [31:0]            boot_addr_i,
  input  wire logic [31:0]            jump_target_i,
  input  wire logic [31:0]            branch_target_i,
  input  wire logic [31:0]            mepc_i,
  input  wire logic [31:0]            nmi_addr_i,
  input  wire logic [23:0]            mtvec_addr_i,

  // Decode side
  output logic                        if_valid_o,
  input  wire logic                   id_ready_i,
  output fetch_pkg::if_id_pipe_t      if_id_pipe_o,
  output logic                        mtvec_init_o,
  output logic                        if_busy_o,

  // Wishbone classic
  output fetch_pkg::wb_req_t          wb_o,
  input  wire logic [31:0]            wb_dat_i,
  input  wire logic                   wb_ack_i,
  input  wire logic                   wb_err_i
);

  // IF stage to prefetch unit
  logic                    flush;
  logic [31:0]             branch_addr;
  logic                    if_ready;
  logic                    fetch_valid;
  fetch_pkg::fetch_entry_t fetch_entry;

  // Prefetch unit to master
  logic                    trans_valid;
  logic [31:0]             trans_addr;
  logic                    trans_ready;
  logic                    resp_valid;
  fetch_pkg::fetch_resp_t  resp;

  if_stage u_if_stage (
    .clk, .rst_n, .ctrl_i,
    .boot_addr_i, .jump_target_i, .branch_target_i, .mepc_i, .nmi_addr_i, .mtvec_addr_i,
    .fetch_valid_i (fetch_valid),
    .fetch_entry_i (fetch_entry),
    .fetch_ready_o (if_ready),
    .flush_o       (flush),
    .branch_addr_o (branch_addr),
    .if_valid_o, .id_ready_i, .if_id_pipe_o, .mtvec_init_o
  );

  prefetch_unit #(.FIFO_DEPTH(FIFO_DEPTH)) u_prefetch_unit (
    .clk, .rst_n,
    .flush_i       (flush),
    .branch_addr_i (branch_addr),
    .fetch_ready_i (if_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_entry_o (fetch_entry),
    .trans_valid_o (trans_valid),
    .trans_addr_o  (trans_addr),
    .trans_ready_i (trans_ready),
    .resp_valid_i  (resp_valid),
    .resp_i        (resp),
    .busy_o        (if_busy_o)
  );

  instr_wb_master u_instr_wb_master (
    .clk, .rst_n,
    .trans_valid_i (trans_valid),
    .trans_addr_i  (trans_addr),
    .trans_ready_o (trans_ready),
    .resp_valid_o  (resp_valid),
    .resp_o        (resp),
    .wb_o, .wb_dat_i, .wb_ack_i, .wb_err_i
  );

endmodule

`default_nettype wire

// File: design/if_stage.sv
`default_nettype none

module if_stage (
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // Controller
  input  wire fetch_pkg::fetch_ctrl_t  ctrl_i,

  // Redirect targets
  input  wire logic [31:0]             boot_addr_i,
  input  wire logic [31:0]             jump_target_i,
  input  wire logic [31:0]             branch_target_i,
  input  wire logic [31:0]             mepc_i,
  input  wire logic [31:0]             nmi_addr_i,
  input  wire logic [23:0]             mtvec_addr_i,

  // From prefetch unit
  input  wire logic                    fetch_valid_i,
  input  wire fetch_pkg::fetch_entry_t fetch_entry_i,
  output logic                         fetch_ready_o,

  // Redirect toward prefetch unit
  output logic                         flush_o,
  output logic [31:0]                  branch_addr_o,

  // Toward decode
  output logic                         if_valid_o,
  input  wire logic                    id_ready_i,
  output fetch_pkg::if_id_pipe_t       if_id_pipe_o,

  output logic                         mtvec_init_o
);

  logic [31:0] branch_addr_n;
  logic        if_ready;
  logic        pipe_load;

  // IF/ID register fields
  logic        pipe_valid_q;
  logic [31:0] pipe_pc_q;
  logic [31:0] pipe_instr_q;
  logic        pipe_err_q;

  ////////////////////
  // Next-PC select
  ////////////////////

  always_comb begin
    branch_addr_n = {boot_addr_i[31:2], 2'b00};
    case (ctrl_i.pc_mux)
      fetch_pkg::PC_BOOT:     branch_addr_n = {boot_addr_i[31:2], 2'b00};
      fetch_pkg::PC_JUMP:     branch_addr_n = {jump_target_i[31:2], 2'b00};
      fetch_pkg::PC_BRANCH:   branch_addr_n = {branch_target_i[31:2], 2'b00};
      // Return from trap
      fetch_pkg::PC_MRET:     branch_addr_n = {mepc_i[31:2], 2'b00};
      // Exceptions share the trap base
      fetch_pkg::PC_TRAP_EXC: branch_addr_n = {mtvec_addr_i, 8'h00};
      // Interrupts vectored one word per id
      fetch_pkg::PC_TRAP_IRQ: branch_addr_n = {mtvec_addr_i, 1'b0, ctrl_i.irq_id, 2'b00};
      fetch_pkg::PC_TRAP_NMI: branch_addr_n = {nmi_addr_i[31:2], 2'b00};
      default:                branch_addr_n = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  assign flush_o       = ctrl_i.pc_set;
  assign branch_addr_o = branch_addr_n;

  // Trap vector base gets its reset value at boot
  assign mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == fetch_pkg::PC_BOOT);

  ////////////////////
  // Handshake
  ////////////////////

  // Kill consumes the head, halt freezes the stage
  assign if_valid_o    = fetch_valid_i && !ctrl_i.kill_if && !ctrl_i.halt_if;
  assign if_ready      = ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if);
  assign fetch_ready_o = if_ready;

  assign pipe_load = if_valid_o && id_ready_i;

  ////////////////////
  // IF/ID register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid_q <= 1'b0;
    end else if (pipe_load) begin
      pipe_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      // Decode took the old one, nothing new
      pipe_valid_q <= 1'b0;
    end
  end

  // Payload only moves on a load
  always_ff @(posedge clk) begin
    if (pipe_load) begin
      pipe_pc_q    <= fetch_entry_i.addr;
      pipe_instr_q <= fetch_entry_i.rdata;
      pipe_err_q   <= fetch_entry_i.bus_err;
    end
  end

  always_comb begin
    if_id_pipe_o.instr_valid = pipe_valid_q;
    if_id_pipe_o.pc          = pipe_pc_q;
    if_id_pipe_o.instr       = pipe_instr_q;
    if_id_pipe_o.bus_err     = pipe_err_q;
  end

endmodule

`default_nettype wire

// File: design/instr_wb_master.sv
`default_nettype none

module instr_wb_master (
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // Request side, from prefetch unit
  input  wire logic                 trans_valid_i,
  input  wire logic [31:0]          trans_addr_i,
  output logic                      trans_ready_o,

  // Response side, one cycle per taken request
  output logic                      resp_valid_o,
  output fetch_pkg::fetch_resp_t    resp_o,

  // Wishbone classic
  output fetch_pkg::wb_req_t        wb_o,
  input  wire logic [31:0]          wb_dat_i,
  input  wire logic                 wb_ack_i,
  input  wire logic                 wb_err_i
);

  typedef enum logic {
    ST_IDLE  = 1'b0,
    ST_CYCLE = 1'b1
  } wb_state_e;

  wb_state_e   state_q;
  logic [31:0] adr_q;
  logic        bus_done;

  // Slave ends the cycle with either ack or err
  assign bus_done = (state_q == ST_CYCLE) && (wb_ack_i || wb_err_i);

  ////////////////////
  // Cycle FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      if (state_q == ST_IDLE && trans_valid_i) begin
        state_q <= ST_CYCLE;
      end else if (bus_done) begin
        // Back to idle, forces one idle cycle on the bus
        state_q <= ST_IDLE;
      end
    end
  end

  // Address captured on accept, held for the whole cycle
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && trans_valid_i) begin
      adr_q <= trans_addr_i;
    end
  end

  // Only accept while idle
  assign trans_ready_o = (state_q == ST_IDLE);

  // Response is passed straight through in the ack/err cycle
  assign resp_valid_o  = bus_done;
  assign resp_o.rdata  = wb_dat_i;
  assign resp_o.err    = wb_err_i;

  // Read-only word fetches
  assign wb_o.cyc = (state_q == ST_CYCLE);
  assign wb_o.stb = (state_q == ST_CYCLE);
  assign wb_o.we  = 1'b0;
  assign wb_o.adr = adr_q;
  assign wb_o.sel = 4'hf;

  ////////////////////
  // Assertions
  ////////////////////

  // Slave never answers with both
  a_ack_err_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_ack_i && wb_err_i));

endmodule

`default_nettype wire

// File: design/prefetch_unit.sv
`default_nettype none

module prefetch_unit #(
  parameter int FIFO_DEPTH = 2
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,

  // Redirect from IF stage
  input  wire logic                  flush_i,
  input  wire logic [31:0]           branch_addr_i,

  // Toward IF stage
  input  wire logic                  fetch_ready_i,
  output logic                       fetch_valid_o,
  output fetch_pkg::fetch_entry_t    fetch_entry_o,

  // Toward bus master
  output logic                       trans_valid_o,
  output logic [31:0]                trans_addr_o,
  input  wire logic                  trans_ready_i,
  input  wire logic                  resp_valid_i,
  input  wire fetch_pkg::fetch_resp_t resp_i,

  output logic                       busy_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // Request address and control
  logic [31:0]      addr_q;
  logic [31:0]      resp_addr_q;
  logic             active_q;
  logic             pending_q;
  logic             discard_q;

  // FIFO storage and pointers
  fetch_pkg::fetch_entry_t fifo_mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  logic             trans_taken;
  logic             fifo_wr;
  logic             fifo_rd;
  logic             fifo_full;
  logic             fifo_space;

  ////////////////////
  // Request side
  ////////////////////

  // Free space counts the request already on the bus
  assign fifo_full  = (cnt_q == CNT_W'(FIFO_DEPTH));
  assign fifo_space = (cnt_q + CNT_W'(pending_q)) < CNT_W'(FIFO_DEPTH);

  // One transfer at a time, nothing in the flush cycle
  assign trans_valid_o = active_q && !pending_q && !flush_i && fifo_space;
  assign trans_addr_o  = addr_q;
  assign trans_taken   = trans_valid_o && trans_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q    <= '0;
      active_q  <= 1'b0;
      pending_q <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      // Stays idle until the first redirect
      if (flush_i) begin
        active_q <= 1'b1;
      end
      // Counter restarts at the redirect target, steps a word per request
      if (flush_i) begin
        addr_q <= branch_addr_i;
      end else if (trans_taken) begin
        addr_q <= addr_q + 32'd4;
      end
      if (trans_taken) begin
        pending_q <= 1'b1;
      end else if (resp_valid_i) begin
        pending_q <= 1'b0;
      end
      // Open cycle at flush belongs to the old stream
      if (resp_valid_i) begin
        discard_q <= 1'b0;
      end else if (flush_i && pending_q) begin
        discard_q <= 1'b1;
      end
    end
  end

  // Address of the word now on the bus
  always_ff @(posedge clk) begin
    if (trans_taken) begin
      resp_addr_q <= addr_q;
    end
  end

  ////////////////////
  // Word FIFO
  ////////////////////

  // Stale or flushed responses never enter
  assign fifo_wr = resp_valid_i && !discard_q && !flush_i;
  assign fifo_rd = fetch_valid_o && fetch_ready_i && !flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // Drop everything buffered
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fifo_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(fifo_wr) - CNT_W'(fifo_rd);
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_wr) begin
      fifo_mem_q[wr_ptr_q] <= '{addr: resp_addr_q, rdata: resp_i.rdata, bus_err: resp_i.err};
    end
  end

  assign fetch_valid_o = (cnt_q != '0);
  assign fetch_entry_o = fifo_mem_q[rd_ptr_q];

  assign busy_o = pending_q || (cnt_q != '0);

  ////////////////////
  // Assertions
  ////////////////////

  // Slot is reserved before the request goes out
  a_no_wr_full : assert property (@(posedge clk) disable iff (!rst_n)
    !(fifo_wr && fifo_full));

  // Master only answers what was asked
  a_resp_pending : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> pending_q);

endmodule

`default_nettype wire

// File: verification/fetch_input.txt
// Header: boot mepc nmi mtvec err_lo err_hi n_pairs n_lines tail_count
@00
00000102 00000600 00000803 00000004 00000600 0000060c 00000008 00000007 00000008
// Image as address/data pairs
@10
00000100 00000013
00000104 00100093
00000108 00200113
0000010c 00308193
00000200 0000006f
00000340 00a00513
0000040c 30200073
00000800 00000073
// Script: count_before pc_mux irq_id target expected_redirect
@30
00000000 00000000 00000000 00000102 00000100
00000006 00000001 00000000 00000200 00000200
00000005 00000002 00000000 00000343 00000340
00000004 00000004 00000000 00000004 00000400
00000004 00000005 00000003 00000004 0000040c
00000004 00000006 00000000 00000803 00000800
00000005 00000003 00000000 00000600 00000600

// File: verification/tb_fetch_top.sv
`default_nettype none

module tb_fetch_top;

  localparam int TIMEOUT = 400;

  logic                   clk;
  logic                   rst_n;
  fetch_pkg::fetch_ctrl_t ctrl;
  logic [31:0]            boot_addr;
  logic [31:0]            jump_target;
  logic [31:0]            branch_target;
  logic [31:0]            mepc;
  logic [31:0]            nmi_addr;
  logic [23:0]            mtvec_addr;
  logic                   id_ready;
  logic                   if_valid;
  fetch_pkg::if_id_pipe_t pipe;
  logic                   mtvec_init;
  logic                   if_busy;
  fetch_pkg::wb_req_t     wb;
  logic [31:0]            wb_dat;
  logic                   wb_ack;
  logic                   wb_err;

  // Input file image, header at 0, pairs at 16, script at 48
  logic [31:0] stim [128];

  // Prediction state
  logic [31:0] exp_pc;
  logic [31:0] skip_pc;
  logic [31:0] redirect_tgt;
  logic        held;
  logic [31:0] held_pc;
  logic [31:0] held_instr;

  // Bus monitor state
  logic [31:0] last_adr;
  logic        prev_stb;
  logic        prev_wait;
  int          init_pulses;

  fetch_top #(.FIFO_DEPTH(2)) dut (
    .clk, .rst_n, .ctrl_i(ctrl),
    .boot_addr_i(boot_addr), .jump_target_i(jump_target), .branch_target_i(branch_target),
    .mepc_i(mepc), .nmi_addr_i(nmi_addr), .mtvec_addr_i(mtvec_addr),
    .if_valid_o(if_valid), .id_ready_i(id_ready), .if_id_pipe_o(pipe),
    .mtvec_init_o(mtvec_init), .if_busy_o(if_busy),
    .wb_o(wb), .wb_dat_i(wb_dat), .wb_ack_i(wb_ack), .wb_err_i(wb_err)
  );

  wb_mem_model u_mem_model (
    .clk, .rst_n, .wb_i(wb), .dat_o(wb_dat), .ack_o(wb_ack), .err_o(wb_err)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp) begin
      $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Image word, or the address based fill
  function automatic logic [31:0] image_word(input logic [31:0] addr);
    for (int i = 0; i < stim[6]; i++) begin
      if (stim[16 + 2 * i] == addr) begin
        return stim[17 + 2 * i];
      end
    end
    return addr ^ 32'h1357_9bdf;
  endfunction

  // One negedge look at IF/ID, accept when decode is ready
  task automatic sample_pipe(output logic accepted);
    logic err_exp;
    accepted = 1'b0;
    if (held) begin
      check_value(pipe.pc, held_pc, "if_id_pipe_o.pc while stalled");
      check_value(pipe.instr, held_instr, "if_id_pipe_o.instr while stalled");
    end
    held       = pipe.instr_valid && !id_ready;
    held_pc    = pipe.pc;
    held_instr = pipe.instr;
    if (pipe.instr_valid && id_ready) begin
      // Killed word drops out of the stream
      if (exp_pc == skip_pc) begin
        exp_pc  = exp_pc + 32'd4;
        skip_pc = '1;
      end
      err_exp = (exp_pc >= stim[4]) && (exp_pc <= stim[5]);
      check_value(pipe.pc, exp_pc, "if_id_pipe_o.pc");
      check_value(pipe.bus_err, err_exp, "if_id_pipe_o.bus_err");
      if (!err_exp) begin
        check_value(pipe.instr, image_word(exp_pc), "if_id_pipe_o.instr");
      end
      exp_pc   = exp_pc + 32'd4;
      accepted = 1'b1;
    end
  endtask

  task automatic accept_n(input int n);
    int   got;
    int   idle;
    logic acc;
    got  = 0;
    idle = 0;
    while (got < n) begin
      @(posedge clk);
      id_ready <= ($urandom % 4) != 0;
      @(negedge clk);
      sample_pipe(acc);
      if (acc) begin
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) report_timeout("the next instruction at IF/ID");
      end
    end
  endtask

  // Stall decode, then kill the FIFO head
  task automatic kill_one();
    int   waited;
    logic acc;
    waited = 0;
    @(posedge clk);
    id_ready <= 1'b0;
    do begin
      @(negedge clk);
      sample_pipe(acc);
      waited++;
      if (waited > TIMEOUT) report_timeout("a fetched word to kill");
    end while (!if_valid);
    skip_pc = pipe.instr_valid ? exp_pc + 32'd4 : exp_pc;
    @(posedge clk);
    ctrl.kill_if <= 1'b1;
    @(posedge clk);
    ctrl.kill_if <= 1'b0;
  endtask

  task automatic halt_stage();
    logic acc;
    for (int k = 0; k < 6; k++) begin
      @(posedge clk);
      ctrl.halt_if <= 1'b1;
      id_ready     <= 1'b1;
      @(negedge clk);
      // Old entry drains in the first cycle, then nothing loads
      if (k > 0) check_value(pipe.instr_valid, 1'b0, "if_id_pipe_o.instr_valid in halt");
      sample_pipe(acc);
    end
    @(posedge clk);
    ctrl.halt_if <= 1'b0;
  endtask

  task automatic redirect(input int base);
    logic [2:0] mux;
    logic [31:0] tgt;
    mux = stim[base + 1][2:0];
    tgt = stim[base + 3];
    @(posedge clk);
    case (mux)
      3'd0:    boot_addr     <= tgt;
      3'd1:    jump_target   <= tgt;
      3'd2:    branch_target <= tgt;
      3'd3:    mepc          <= tgt;
      3'd4,
      3'd5:    mtvec_addr    <= tgt[23:0];
      default: nmi_addr      <= tgt;
    endcase
    // Controller kills the old head with every redirect
    ctrl.pc_set  <= 1'b1;
    ctrl.pc_mux  <= fetch_pkg::pc_mux_e'(mux);
    ctrl.irq_id  <= stim[base + 2][4:0];
    ctrl.kill_if <= 1'b1;
    id_ready     <= 1'b1;
    redirect_tgt = stim[base + 4];
    exp_pc       = stim[base + 4];
    skip_pc      = '1;
    held         = 1'b0;
    @(posedge clk);
    ctrl <= '0;
  endtask

  task automatic run_segment(input int n);
    accept_n(n / 2);
    if (n >= 4) begin
      kill_one();
      halt_stage();
    end
    accept_n(n - n / 2);
  endtask

  ////////////////////
  // Bus monitor
  ////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      check_value(wb.cyc, wb.stb, "wb_o.cyc");
      if (prev_wait) begin
        check_value(wb.stb, 1'b1, "wb_o.stb before ack");
        check_value(wb.adr, last_adr, "wb_o.adr before ack");
      end
      if (wb.stb && !prev_stb) begin
        check_value(wb.adr[1:0], 2'b00, "wb_o.adr[1:0]");
        check_value(wb.adr, (wb.adr == redirect_tgt) ? redirect_tgt : last_adr + 32'd4,
                    "wb_o.adr sequence");
      end
      // Prefetch sits idle until the first redirect
      if (redirect_tgt === '1) begin
        check_value(if_busy, 1'b0, "if_busy_o before boot");
        check_value(if_valid, 1'b0, "if_valid_o before boot");
      end
      // Open bus cycle or buffered word means busy
      if (wb.cyc || if_valid) check_value(if_busy, 1'b1, "if_busy_o");
      // Kill and halt hide the head from decode
      if (ctrl.kill_if || ctrl.halt_if) check_value(if_valid, 1'b0, "if_valid_o");
      if (wb.stb) last_adr = wb.adr;
      prev_stb  = wb.stb;
      prev_wait = wb.stb && !wb_ack && !wb_err;
      if (mtvec_init) init_pulses++;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(32'h0e80544a));
    rst_n         = 1'b0;
    ctrl          = '0;
    id_ready      = 1'b0;
    jump_target   = '0;
    branch_target = '0;
    exp_pc        = '0;
    skip_pc       = '1;
    redirect_tgt  = '1;
    held          = 1'b0;
    last_adr      = '0;
    prev_stb      = 1'b0;
    prev_wait     = 1'b0;
    init_pulses   = 0;
    $readmemh("verification/fetch_input.txt", stim);
    boot_addr  = stim[0];
    mepc       = stim[1];
    nmi_addr   = stim[2];
    mtvec_addr = stim[3][23:0];
    u_mem_model.set_err_range(stim[4], stim[5]);
    for (int i = 0; i < stim[6]; i++) begin
      u_mem_model.load_word(stim[16 + 2 * i], stim[17 + 2 * i]);
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int l = 0; l < stim[7]; l++) begin
      run_segment(stim[48 + 5 * l]);
      redirect(48 + 5 * l);
    end
    run_segment(stim[8]);
    check_value(init_pulses, 1, "mtvec_init_o pulse count");
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/wb_mem_model.sv
`default_nettype none

module wb_mem_model (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire fetch_pkg::wb_req_t wb_i,
  output logic [31:0]             dat_o,
  output logic                    ack_o,
  output logic                    err_o
);

  // Word storage for a 4 KiB window
  logic [31:0] mem [1024];
  logic        loaded [1024];

  // Inclusive range that answers with err
  logic [31:0] err_lo;
  logic [31:0] err_hi;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      loaded[i] = 1'b0;
    end
    err_lo = 32'hffff_ffff;
    err_hi = 32'h0000_0000;
  end

  ////////////////////
  // Loading
  ////////////////////

  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[11:2]]    = data;
    loaded[addr[11:2]] = 1'b1;
  endtask

  task automatic set_err_range(input logic [31:0] lo, input logic [31:0] hi);
    err_lo = lo;
    err_hi = hi;
  endtask

  // Unloaded words follow the full address
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (addr[31:12] == '0 && loaded[addr[11:2]]) begin
      return mem[addr[11:2]];
    end
    return addr ^ 32'h1357_9bdf;
  endfunction

  ////////////////////
  // Slave response
  ////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      dat_o <= '0;
    end else begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      // Random wait states, one answer per cycle
      if (wb_i.cyc && wb_i.stb && !ack_o && !err_o && ($urandom % 3 == 0)) begin
        if (wb_i.adr >= err_lo && wb_i.adr <= err_hi) begin
          err_o <= 1'b1;
          dat_o <= '0;
        end else begin
          ack_o <= 1'b1;
          dat_o <= read_word(wb_i.adr);
        end
      end
    end
  end

endmodule

`default_nettype wire
